// ==== udma_pkg.sv ====
/*
 * uDMA channel package
 * Shared widths, APB register offsets and engine state encodings
 */
package udma_pkg;

    //////////////////////////////
    // Widths and sizes
    //////////////////////////////
    localparam int L2_AW     = 12;   // L2 byte address
    localparam int TRANS_SW  = 16;   // Transfer size in bytes
    localparam int DATA_W    = 32;   // Stream and memory word
    localparam int APB_AW    = 5;
    localparam int APB_DW    = 32;
    localparam int MEM_DEPTH = 4096; // L2 bytes

    // Bit positions inside RX_CFG / TX_CFG
    localparam int CFG_EN_BIT   = 4;
    localparam int CFG_PEND_BIT = 5;

    //////////////////////////////
    // Register map
    //////////////////////////////
    typedef enum logic [4:0] {
        RX_SADDR = 5'h00, // RX start address in L2
        RX_SIZE  = 5'h04, // RX size in bytes
        RX_CFG   = 5'h08, // RX enable, bytes left in upper half
        TX_SADDR = 5'h0C, // TX start address in L2
        TX_SIZE  = 5'h10, // TX size in bytes
        TX_CFG   = 5'h14, // TX enable
        STATUS   = 5'h18  // Busy bits and TX bytes left
    } udma_reg_e;

    // Engine FSM states, DRAIN is used by TX only
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } chan_state_e;

endpackage

// ==== udma_apb_regs.sv ====
/*
 * uDMA channel register block
 * Zero-wait APB slave with RX/TX address, size and enable registers, and status
 */
module udma_apb_regs (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [udma_pkg::APB_AW-1:0]   paddr_i,
    input  logic [udma_pkg::APB_DW-1:0]   pwdata_i,
    output logic [udma_pkg::APB_DW-1:0]   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    input  logic                          rx_busy_i,
    input  logic [udma_pkg::TRANS_SW-1:0] rx_bytes_left_i,
    input  logic                          tx_busy_i,
    input  logic [udma_pkg::TRANS_SW-1:0] tx_bytes_left_i,
    output logic                          rx_start_o,
    output logic [udma_pkg::L2_AW-1:0]    rx_saddr_o,
    output logic [udma_pkg::TRANS_SW-1:0] rx_size_o,
    output logic                          tx_start_o,
    output logic [udma_pkg::L2_AW-1:0]    tx_saddr_o,
    output logic [udma_pkg::TRANS_SW-1:0] tx_size_o
);
    import udma_pkg::*;

    logic [L2_AW-1:2]    rx_saddr_q;  // Word aligned, bits 1:0 always zero
    logic [TRANS_SW-1:0] rx_size_q;
    logic [L2_AW-1:2]    tx_saddr_q;
    logic [TRANS_SW-1:0] tx_size_q;
    logic                access;
    logic                reg_hit;
    logic [APB_DW-1:0]   rdata;

    assign access   = psel_i & penable_i;
    assign pready_o = 1'b1;              // No wait states

    //////////////////////////////
    // Decode and read mux
    //////////////////////////////
    always_comb begin
        reg_hit = 1'b1;
        rdata   = '0;
        case (udma_reg_e'(paddr_i))
            RX_SADDR: rdata = APB_DW'({rx_saddr_q, 2'b00});
            RX_SIZE:  rdata = APB_DW'(rx_size_q);
            RX_CFG: begin
                rdata[CFG_EN_BIT]             = rx_busy_i;
                rdata[CFG_PEND_BIT]           = rx_start_o; // Start not yet taken
                rdata[APB_DW-1 -: TRANS_SW]   = rx_bytes_left_i;
            end
            TX_SADDR: rdata = APB_DW'({tx_saddr_q, 2'b00});
            TX_SIZE:  rdata = APB_DW'(tx_size_q);
            TX_CFG: begin
                rdata[CFG_EN_BIT]   = tx_busy_i;
                rdata[CFG_PEND_BIT] = tx_start_o;
            end
            STATUS: begin
                rdata[0]                    = rx_busy_i;
                rdata[1]                    = tx_busy_i;
                rdata[APB_DW-1 -: TRANS_SW] = tx_bytes_left_i;
            end
            default: reg_hit = 1'b0;   // Unmapped offset
        endcase
    end

    assign prdata_o  = rdata;
    assign pslverr_o = access & ~reg_hit;

    //////////////////////////////
    // Register writes
    //////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_saddr_q <= '0;
            rx_size_q  <= '0;
            tx_saddr_q <= '0;
            tx_size_q  <= '0;
            rx_start_o <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            rx_start_o <= 1'b0;   // Start is a single-cycle pulse
            tx_start_o <= 1'b0;
            if (access && pwrite_i && reg_hit) begin
                case (udma_reg_e'(paddr_i))
                    RX_SADDR: rx_saddr_q <= pwdata_i[L2_AW-1:2];
                    RX_SIZE:  rx_size_q  <= pwdata_i[TRANS_SW-1:0];
                    RX_CFG: begin
                        // Only an idle channel with a nonzero size is started
                        rx_start_o <= pwdata_i[CFG_EN_BIT] & ~rx_busy_i & (rx_size_q != '0);
                    end
                    TX_SADDR: tx_saddr_q <= pwdata_i[L2_AW-1:2];
                    TX_SIZE:  tx_size_q  <= pwdata_i[TRANS_SW-1:0];
                    TX_CFG: begin
                        tx_start_o <= pwdata_i[CFG_EN_BIT] & ~tx_busy_i & (tx_size_q != '0);
                    end
                    default: ;            // STATUS is read only
                endcase
            end
        end
    end

    assign rx_saddr_o = {rx_saddr_q, 2'b00};
    assign rx_size_o  = rx_size_q;
    assign tx_saddr_o = {tx_saddr_q, 2'b00};
    assign tx_size_o  = tx_size_q;

endmodule

// ==== udma_l2_mem.sv ====
/*
 * Local L2 memory
 * Byte array accessed as little-endian words, one write port and a registered read port
 */
module udma_l2_mem (
    input  logic                        sys_clk,
    input  logic                        wr_en_i,
    input  logic [udma_pkg::L2_AW-3:0]  wr_addr_i,
    input  logic [udma_pkg::DATA_W-1:0] wr_data_i,
    input  logic                        rd_en_i,
    input  logic [udma_pkg::L2_AW-3:0]  rd_addr_i,
    output logic [udma_pkg::DATA_W-1:0] rd_data_o
);
    import udma_pkg::*;

    localparam int BYTES_PER_WORD = DATA_W / 8;

    logic [7:0] mem_q [MEM_DEPTH];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (wr_en_i) begin
            for (int k = 0; k < BYTES_PER_WORD; k++) begin
                mem_q[{wr_addr_i, k[1:0]}] <= wr_data_i[8*k +: 8]; // Byte 0 at lowest address
            end
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////
    // A collision with a write to the same word returns the old contents
    always_ff @(posedge sys_clk) begin
        if (rd_en_i) begin
            for (int k = 0; k < BYTES_PER_WORD; k++) begin
                rd_data_o[8*k +: 8] <= mem_q[{rd_addr_i, k[1:0]}];
            end
        end
    end

endmodule

// ==== udma_rx_stream.sv ====
/*
 * RX stream engine
 * Stores incoming stream words into L2 from the start address on
 */
module udma_rx_stream (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic [udma_pkg::L2_AW-1:0]    saddr_i,
    input  logic [udma_pkg::TRANS_SW-1:0] size_i,
    input  logic [udma_pkg::DATA_W-1:0]   rx_data_i,
    input  logic                          rx_valid_i,
    output logic                          rx_ready_o,
    output logic                          mem_wr_en_o,
    output logic [udma_pkg::L2_AW-3:0]    mem_wr_addr_o,
    output logic [udma_pkg::DATA_W-1:0]   mem_wr_data_o,
    output logic                          busy_o,
    output logic [udma_pkg::TRANS_SW-1:0] bytes_left_o,
    output logic                          rx_eot_o
);
    import udma_pkg::*;

    chan_state_e         state_q;
    logic [L2_AW-3:0]    waddr_q;      // Word address, wraps with L2
    logic [TRANS_SW-1:0] size_q;
    logic [TRANS_SW-1:0] words_tot_q;
    logic [TRANS_SW-1:0] words_done_q;
    logic [TRANS_SW+1:0] bytes_done;
    logic                accept;
    logic                last_word;

    assign rx_ready_o = (state_q == RUN);
    assign busy_o     = (state_q == RUN);
    assign accept     = rx_ready_o & rx_valid_i;
    assign last_word  = accept & (words_done_q == words_tot_q - 1'b1);

    // Every accepted word goes to L2 in the same cycle
    assign mem_wr_en_o   = accept;
    assign mem_wr_addr_o = waddr_q;
    assign mem_wr_data_o = rx_data_i;

    assign bytes_done   = {words_done_q, 2'b00};
    assign bytes_left_o = (bytes_done >= {2'b00, size_q}) ? '0 :
                          size_q - bytes_done[TRANS_SW-1:0];

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            waddr_q      <= '0;
            size_q       <= '0;
            words_tot_q  <= '0;
            words_done_q <= '0;
            rx_eot_o     <= 1'b0;
        end else begin
            rx_eot_o <= last_word;  // One cycle after the last word
            if (start_i) begin
                state_q      <= RUN;
                waddr_q      <= saddr_i[L2_AW-1:2];
                size_q       <= size_i;
                words_tot_q  <= {2'b00, size_i[TRANS_SW-1:2]} + TRANS_SW'(|size_i[1:0]);
                words_done_q <= '0;
            end else if (accept) begin
                waddr_q      <= waddr_q + 1'b1;
                words_done_q <= words_done_q + 1'b1;
                if (last_word) begin
                    state_q <= IDLE;
                end
            end
        end
    end

endmodule

// ==== udma_tx_stream.sv ====
/*
 * TX stream engine
 * Fetches words from L2 and streams them out, two reads in flight or buffered
 */
module udma_tx_stream (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic [udma_pkg::L2_AW-1:0]    saddr_i,
    input  logic [udma_pkg::TRANS_SW-1:0] size_i,
    output logic                          mem_rd_en_o,
    output logic [udma_pkg::L2_AW-3:0]    mem_rd_addr_o,
    input  logic [udma_pkg::DATA_W-1:0]   mem_rd_data_i,
    output logic [udma_pkg::DATA_W-1:0]   tx_data_o,
    output logic                          tx_valid_o,
    input  logic                          tx_ready_i,
    output logic                          busy_o,
    output logic [udma_pkg::TRANS_SW-1:0] bytes_left_o,
    output logic                          tx_eot_o
);
    import udma_pkg::*;

    chan_state_e         state_q;
    logic [L2_AW-3:0]    raddr_q;
    logic [TRANS_SW-1:0] size_q;
    logic [TRANS_SW-1:0] words_tot_q;
    logic [TRANS_SW-1:0] issue_left_q;  // Reads still to issue
    logic [TRANS_SW-1:0] words_done_q;  // Words accepted downstream
    logic [DATA_W-1:0]   buf_q [2];
    logic                buf_wptr_q;
    logic                buf_rptr_q;
    logic [1:0]          buf_cnt_q;
    logic                inflight_q;    // Read data arrives next cycle
    logic [1:0]          occ_nxt;
    logic                pop;
    logic                last_word;
    logic [TRANS_SW+1:0] bytes_done;

    assign tx_valid_o = (buf_cnt_q != 2'd0);
    assign tx_data_o  = buf_q[buf_rptr_q];  // Head holds still under back-pressure
    assign pop        = tx_valid_o & tx_ready_i;
    assign last_word  = pop & (words_done_q == words_tot_q - 1'b1);
    assign busy_o     = (state_q != IDLE);

    // Buffered plus in-flight words after this cycle's pop
    assign occ_nxt       = buf_cnt_q + {1'b0, inflight_q} - {1'b0, pop};
    assign mem_rd_en_o   = (state_q == RUN) & (occ_nxt < 2'd2);
    assign mem_rd_addr_o = raddr_q;

    assign bytes_done   = {words_done_q, 2'b00};
    assign bytes_left_o = (bytes_done >= {2'b00, size_q}) ? '0 :
                          size_q - bytes_done[TRANS_SW-1:0];

    always_ff @(posedge sys_clk) begin
        if (inflight_q) begin
            buf_q[buf_wptr_q] <= mem_rd_data_i;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            raddr_q      <= '0;
            size_q       <= '0;
            words_tot_q  <= '0;
            issue_left_q <= '0;
            words_done_q <= '0;
            buf_wptr_q   <= 1'b0;
            buf_rptr_q   <= 1'b0;
            buf_cnt_q    <= 2'd0;
            inflight_q   <= 1'b0;
            tx_eot_o     <= 1'b0;
        end else begin
            tx_eot_o   <= last_word;
            inflight_q <= mem_rd_en_o;
            buf_cnt_q  <= occ_nxt;
            if (inflight_q) buf_wptr_q <= ~buf_wptr_q;
            if (pop) begin
                buf_rptr_q   <= ~buf_rptr_q;
                words_done_q <= words_done_q + 1'b1;
            end
            if (start_i) begin
                state_q      <= RUN;
                raddr_q      <= saddr_i[L2_AW-1:2];
                size_q       <= size_i;
                words_tot_q  <= {2'b00, size_i[TRANS_SW-1:2]} + TRANS_SW'(|size_i[1:0]);
                issue_left_q <= {2'b00, size_i[TRANS_SW-1:2]} + TRANS_SW'(|size_i[1:0]);
                words_done_q <= '0;
            end else begin
                case (state_q)
                    RUN: if (mem_rd_en_o) begin
                        raddr_q      <= raddr_q + 1'b1;
                        issue_left_q <= issue_left_q - 1'b1;
                        if (issue_left_q == TRANS_SW'(1)) state_q <= DRAIN; // Last read out
                    end
                    DRAIN: if (last_word) state_q <= IDLE;
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

endmodule

// ==== udma_channel_top.sv ====
/*
 * uDMA channel top level
 * APB register block, RX and TX stream engines and the local L2 memory
 */
module udma_channel_top (
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [udma_pkg::APB_AW-1:0] paddr_i,
    input  logic [udma_pkg::APB_DW-1:0] pwdata_i,
    output logic [udma_pkg::APB_DW-1:0] prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    input  logic [udma_pkg::DATA_W-1:0] rx_data_i,
    input  logic                        rx_valid_i,
    output logic                        rx_ready_o,
    output logic [udma_pkg::DATA_W-1:0] tx_data_o,
    output logic                        tx_valid_o,
    input  logic                        tx_ready_i,
    output logic                        rx_eot_o,
    output logic                        tx_eot_o
);
    import udma_pkg::*;

    logic                rx_start, tx_start;
    logic [L2_AW-1:0]    rx_saddr, tx_saddr;
    logic [TRANS_SW-1:0] rx_size, tx_size;
    logic                rx_busy, tx_busy;
    logic [TRANS_SW-1:0] rx_bytes_left, tx_bytes_left;
    logic                mem_wr_en, mem_rd_en;
    logic [L2_AW-3:0]    mem_wr_addr, mem_rd_addr;
    logic [DATA_W-1:0]   mem_wr_data, mem_rd_data;

    udma_apb_regs udma_apb_regs_i (
        .sys_clk, .rst_n,
        .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .rx_busy_i       (rx_busy),
        .rx_bytes_left_i (rx_bytes_left),
        .tx_busy_i       (tx_busy),
        .tx_bytes_left_i (tx_bytes_left),
        .rx_start_o      (rx_start),
        .rx_saddr_o      (rx_saddr),
        .rx_size_o       (rx_size),
        .tx_start_o      (tx_start),
        .tx_saddr_o      (tx_saddr),
        .tx_size_o       (tx_size)
    );

    udma_rx_stream udma_rx_stream_i (
        .sys_clk, .rst_n,
        .start_i       (rx_start),
        .saddr_i       (rx_saddr),
        .size_i        (rx_size),
        .rx_data_i, .rx_valid_i, .rx_ready_o,
        .mem_wr_en_o   (mem_wr_en),
        .mem_wr_addr_o (mem_wr_addr),
        .mem_wr_data_o (mem_wr_data),
        .busy_o        (rx_busy),
        .bytes_left_o  (rx_bytes_left),
        .rx_eot_o
    );

    udma_tx_stream udma_tx_stream_i (
        .sys_clk, .rst_n,
        .start_i       (tx_start),
        .saddr_i       (tx_saddr),
        .size_i        (tx_size),
        .mem_rd_en_o   (mem_rd_en),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .tx_data_o, .tx_valid_o, .tx_ready_i,
        .busy_o        (tx_busy),
        .bytes_left_o  (tx_bytes_left),
        .tx_eot_o
    );

    udma_l2_mem udma_l2_mem_i (
        .sys_clk,
        .wr_en_i   (mem_wr_en),
        .wr_addr_i (mem_wr_addr),
        .wr_data_i (mem_wr_data),
        .rd_en_i   (mem_rd_en),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data)
    );

endmodule

// ==== udma_channel_checker.sv ====
/*
 * uDMA channel protocol checker
 * Bound to the channel top level, watches the TX stream, APB error and end-of-transfer ports
 */
module udma_channel_checker (
    input logic                        sys_clk,
    input logic                        rst_n,
    input logic                        psel_i,
    input logic                        penable_i,
    input logic                        pslverr_o,
    input logic [udma_pkg::DATA_W-1:0] tx_data_o,
    input logic                        tx_valid_o,
    input logic                        tx_ready_i,
    input logic                        rx_eot_o,
    input logic                        tx_eot_o
);
    int fail_cnt = 0;   // Assertion failure count

    // Output word holds under back-pressure
    tx_hold_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
        else begin
            $error("tx_data_o changed or tx_valid_o dropped under back-pressure");
            fail_cnt++;
        end

    slverr_phase_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
        pslverr_o |-> psel_i && penable_i)
        else begin
            $error("pslverr_o high outside an APB access phase");
            fail_cnt++;
        end

    rx_eot_pulse_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rx_eot_o |=> !rx_eot_o)
        else begin
            $error("rx_eot_o high for more than one cycle");
            fail_cnt++;
        end

    tx_eot_pulse_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_eot_o |=> !tx_eot_o)
        else begin
            $error("tx_eot_o high for more than one cycle");
            fail_cnt++;
        end

    tx_reset_a: assert property (@(posedge sys_clk) $rose(rst_n) |-> !tx_valid_o)
        else begin
            $error("tx_valid_o high when leaving reset");
            fail_cnt++;
        end

endmodule

bind udma_channel_top udma_channel_checker udma_channel_checker_i (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pslverr_o  (pslverr_o),
    .tx_data_o  (tx_data_o),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .rx_eot_o   (rx_eot_o),
    .tx_eot_o   (tx_eot_o)
);

// ==== tb_udma_channel.sv ====
/*
 * uDMA channel testbench
 * Table-driven RX then TX transfers over APB, checked against an L2 word model
 */
module tb_udma_channel;
    import udma_pkg::*;

    logic              sys_clk;
    logic              rst_n;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [APB_DW-1:0] pwdata_i;
    logic [APB_DW-1:0] prdata_o;
    logic              pready_o;
    logic              pslverr_o;
    logic [DATA_W-1:0] rx_data_i;
    logic              rx_valid_i;
    logic              rx_ready_o;
    logic [DATA_W-1:0] tx_data_o;
    logic              tx_valid_o;
    logic              tx_ready_i;
    logic              rx_eot_o;
    logic              tx_eot_o;
    logic [DATA_W-1:0] model [MEM_DEPTH/4];   // Expected L2 contents per word
    int                timeout_cycles = 400;

    // Transfer table: start address, size in bytes, start expected
    logic [31:0] saddr_tab [5] = '{32'h0000_0010, 32'hFFFF_F103, 32'h0000_0FF4,
                                   32'h0000_0200, 32'h0000_0080};
    logic [31:0] size_tab  [5] = '{32'h0000_0020, 32'hABCD_0016, 32'h0000_0028,
                                   32'h0000_0000, 32'h0000_000D};
    logic        start_tab [5] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    udma_channel_top udma_channel_top_i (.*);

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else stop_on_error($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                         name, got, exp));
    endtask

    //////////////////////////////
    // APB master
    //////////////////////////////
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        @(posedge sys_clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge sys_clk);
        penable_i <= 1'b1;
        @(posedge sys_clk);             // Access phase ends, write lands
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        @(posedge sys_clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        @(posedge sys_clk);
        penable_i <= 1'b1;
        @(negedge sys_clk);             // Mid access phase
        assert (pready_o) else stop_on_error("pready_o low during an APB access phase");
        data = prdata_o;
        err  = pslverr_o;
        @(posedge sys_clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic read_check(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                              input string name);
        logic [APB_DW-1:0] data;
        logic              err;
        apb_read(addr, data, err);
        check_eq({"prdata_o (", name, ")"}, data, exp);
        check_eq({"pslverr_o (", name, ")"}, 32'(err), 32'h0);
    endtask

    //////////////////////////////
    // Stream side helpers
    //////////////////////////////
    // 0 rx_ready_o, 1 tx_valid_o, 2 rx_eot_o, 3 tx_eot_o
    function automatic logic port_level(input int sel);
        case (sel)
            0:       return rx_ready_o;
            1:       return tx_valid_o;
            2:       return rx_eot_o;
            default: return tx_eot_o;
        endcase
    endfunction

    task automatic wait_for_high(input int sel, input string name);
        int guard;
        guard = 0;
        @(negedge sys_clk);
        while (!port_level(sel)) begin
            guard++;
            assert (guard < timeout_cycles) else stop_on_error({"Timeout waiting for ", name});
            @(negedge sys_clk);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            assert (!rx_ready_o && !tx_valid_o && !rx_eot_o && !tx_eot_o)
                else stop_on_error("Stream activity or end-of-transfer pulse on an idle channel");
        end
    endtask

    task automatic send_rx(input int n_words, input logic [L2_AW-3:0] waddr);
        int                sent;
        int                guard;
        logic [DATA_W-1:0] word;
        sent  = 0;
        guard = 0;
        word  = $urandom;
        @(posedge sys_clk);
        rx_valid_i <= 1'b1;
        rx_data_i  <= word;
        while (sent < n_words) begin
            @(negedge sys_clk);
            if (rx_ready_o) begin       // Taken at the next rising edge
                model[waddr] = word;
                waddr = waddr + 1'b1;
                sent++;
                guard = 0;
                word  = $urandom;
                @(posedge sys_clk);
                rx_valid_i <= (sent < n_words);
                rx_data_i  <= word;
            end else begin
                guard++;
                assert (guard < timeout_cycles) else stop_on_error("Timeout: RX stream stalled");
            end
        end
    endtask

    task automatic recv_tx(input int n_words, input logic [L2_AW-3:0] waddr);
        int got;
        int guard;
        got   = 0;
        guard = 0;
        while (got < n_words) begin
            @(posedge sys_clk);
            tx_ready_i <= (($urandom % 3) != 0);   // Back-pressure about a third of the time
            @(negedge sys_clk);
            if (tx_valid_o && tx_ready_i) begin
                check_eq("tx_data_o", tx_data_o, model[waddr]);
                waddr = waddr + 1'b1;
                got++;
                guard = 0;
            end else begin
                guard++;
                assert (guard < timeout_cycles) else stop_on_error("Timeout: TX stream stalled");
            end
        end
        @(posedge sys_clk);
        tx_ready_i <= 1'b0;
    endtask

    // One table entry in one direction, register setup through end of transfer
    task automatic run_direction(input logic is_tx, input int e);
        logic [APB_AW-1:0] base;
        logic [31:0]       saddr_exp;
        logic [31:0]       size_exp;
        logic [31:0]       left_exp;
        logic [L2_AW-3:0]  waddr;
        int                n_words;
        int                half;
        string             tag;
        base      = is_tx ? TX_SADDR : RX_SADDR;
        tag       = is_tx ? "TX" : "RX";
        saddr_exp = saddr_tab[e] & 32'h0000_0FFC;
        size_exp  = size_tab[e] & 32'h0000_FFFF;
        n_words   = int'((size_exp + 32'd3) / 32'd4);
        half      = n_words / 2;
        left_exp  = size_exp - 32'(4 * half);
        waddr     = saddr_exp[L2_AW-1:2];
        apb_write(base, saddr_tab[e]);
        apb_write(base + 5'd4, size_tab[e]);
        read_check(base, saddr_exp, {tag, "_SADDR"});
        read_check(base + 5'd4, size_exp, {tag, "_SIZE"});
        apb_write(base + 5'd8, 32'h1 << CFG_EN_BIT);
        if (start_tab[e]) begin
            wait_for_high(is_tx ? 1 : 0, is_tx ? "tx_valid_o" : "rx_ready_o");
            if (is_tx) begin
                recv_tx(half, waddr);
            end else begin
                send_rx(half, waddr);
            end
            waddr = waddr + half[L2_AW-3:0];
            apb_write(base + 5'd8, 32'h1 << CFG_EN_BIT);   // Busy mid transfer, no restart
            read_check(base + 5'd8, is_tx ? 32'h10 : {left_exp[15:0], 16'h0010}, {tag, "_CFG"});
            read_check(STATUS, is_tx ? {left_exp[15:0], 16'h0002} : 32'h1, "STATUS");
            if (is_tx) begin
                recv_tx(n_words - half, waddr);
            end else begin
                send_rx(n_words - half, waddr);
            end
            wait_for_high(is_tx ? 3 : 2, is_tx ? "tx_eot_o" : "rx_eot_o");
            assert (!port_level(is_tx ? 1 : 0))
                else stop_on_error({tag, " stream still active after end of transfer"});
        end
        expect_quiet(4);
        read_check(STATUS, 32'h0, "STATUS");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        logic [APB_DW-1:0] rdata;
        logic              err;
        void'($urandom(40));
        rst_n      = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        rx_data_i  = '0;
        rx_valid_i = 1'b0;
        tx_ready_i = 1'b0;
        repeat (5) @(posedge sys_clk);
        rst_n <= 1'b1;
        @(negedge sys_clk);
        assert (!rx_ready_o && !tx_valid_o && !rx_eot_o && !tx_eot_o && !pslverr_o)
            else stop_on_error("DUT outputs not idle after reset");
        read_check(STATUS, 32'h0, "STATUS");
        read_check(RX_CFG, 32'h0, "RX_CFG");
        read_check(TX_CFG, 32'h0, "TX_CFG");
        apb_read(5'h1C, rdata, err);    // Unmapped offset
        check_eq("pslverr_o (0x1C)", 32'(err), 32'h1);
        check_eq("prdata_o (0x1C)", rdata, 32'h0);

        for (int e = 0; e < 5; e++) begin
            run_direction(1'b0, e);
            run_direction(1'b1, e);
        end

        if (udma_channel_top_i.udma_channel_checker_i.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "Protocol assertions failed in the bound checker");
        end
    end

endmodule

// ==== list.f ====
udma_pkg.sv
udma_apb_regs.sv
udma_l2_mem.sv
udma_rx_stream.sv
udma_tx_stream.sv
udma_channel_top.sv
udma_channel_checker.sv
tb_udma_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the uDMA channel testbench with Verilator and run it
# The run passes only when the simulation log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_udma_channel -f list.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_udma_channel +verilator+error+limit+100 > sim.log 2>&1 || true
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" || {
    cat sim.log
    echo "Simulation failed"
    exit 1
}
